/* include/muldiv_defines.svh */
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// Datapath width.
`define MD_XLEN 32

// Register index width.
`define MD_REG_W 5

// Booth steps after the top group, which is folded into the load.
`define MD_MUL_ITERS 16

// One quotient bit per step.
`define MD_DIV_ITERS 32

`endif

/* hdl/muldiv_pkg.sv */
`include "muldiv_defines.svh"

package muldiv_pkg;

    // Multiplier operations.
    typedef enum logic [1:0] {
        MUL_W   = 2'd0,  // Low word.
        MULH_W  = 2'd1,  // High word, signed.
        MULH_WU = 2'd2   // High word, unsigned.
    } mul_op_t;

    // Divider operations.
    typedef enum logic [1:0] {
        DIV_W  = 2'd0,
        MOD_W  = 2'd1,
        DIV_WU = 2'd2,
        MOD_WU = 2'd3
    } div_op_t;

    // Operation code as seen at the execute input.
    typedef enum logic [2:0] {
        OP_MUL_W   = 3'd0,
        OP_MULH_W  = 3'd1,
        OP_MULH_WU = 3'd2,
        OP_DIV_W   = 3'd3,
        OP_MOD_W   = 3'd4,
        OP_DIV_WU  = 3'd5,
        OP_MOD_WU  = 3'd6
    } md_op_t;

    typedef struct packed {
        logic [`MD_REG_W-1:0] dest;
        logic [`MD_XLEN-1:0]  pc;
        logic [`MD_XLEN-1:0]  result;
    } commit_t;

endpackage

/* hdl/exu_req_if.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

// Operation request from the issue stage to one execute unit.
interface exu_req_if #(
    parameter type op_t = logic [1:0]
);
    logic                 valid;
    logic                 ready;
    op_t                  op;
    logic [`MD_XLEN-1:0]  src1;
    logic [`MD_XLEN-1:0]  src2;
    logic [`MD_REG_W-1:0] dest;
    logic [`MD_XLEN-1:0]  pc;

    modport issuer (
        output valid, op, src1, src2, dest, pc,
        input  ready
    );

    modport unit (
        input  valid, op, src1, src2, dest, pc,
        output ready
    );
endinterface

/* hdl/exu_resp_if.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

// Result from one execute unit to the commit stage.
interface exu_resp_if;
    logic                 valid;
    logic                 ready;
    logic [`MD_XLEN-1:0]  result;
    logic [`MD_REG_W-1:0] dest;
    logic [`MD_XLEN-1:0]  pc;

    modport unit (
        output valid, result, dest, pc,
        input  ready
    );

    modport commit (
        input  valid, result, dest, pc,
        output ready
    );
endinterface

/* hdl/ex_issue.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module ex_issue import muldiv_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  md_op_t               in_op,
    input  logic [`MD_XLEN-1:0]  in_src1,
    input  logic [`MD_XLEN-1:0]  in_src2,
    input  logic [`MD_REG_W-1:0] in_dest,
    input  logic [`MD_XLEN-1:0]  in_pc,
    output logic                 in_ready,
    input  logic                 commit_fire,
    exu_req_if.issuer            mul_req,
    exu_req_if.issuer            div_req
);
    logic                 busy;
    logic                 mul_vld;
    logic                 div_vld;
    md_op_t               op_q;
    logic [`MD_XLEN-1:0]  src1_q;
    logic [`MD_XLEN-1:0]  src2_q;
    logic [`MD_REG_W-1:0] dest_q;
    logic [`MD_XLEN-1:0]  pc_q;
    mul_op_t              mul_op;
    div_op_t              div_op;
    logic                 in_fire;
    logic                 is_mul;

    assign in_ready = ~busy;  // One operation in flight.
    assign in_fire  = in_valid & in_ready;
    assign is_mul   = in_op inside {OP_MUL_W, OP_MULH_W, OP_MULH_WU};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            mul_vld <= 1'b0;
            div_vld <= 1'b0;
        end else begin
            if (in_fire) begin
                busy    <= 1'b1;
                mul_vld <= is_mul;
                div_vld <= ~is_mul;
            end else begin
                if (commit_fire) begin
                    busy <= 1'b0;
                end
                if (mul_req.valid && mul_req.ready) begin
                    mul_vld <= 1'b0;
                end
                if (div_req.valid && div_req.ready) begin
                    div_vld <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            op_q   <= in_op;
            src1_q <= in_src1;
            src2_q <= in_src2;
            dest_q <= in_dest;
            pc_q   <= in_pc;
        end
    end

    // Split the combined code into the unit encodings.
    always_comb begin
        mul_op = MUL_W;
        div_op = DIV_W;
        case (op_q)
            OP_MULH_W:  mul_op = MULH_W;
            OP_MULH_WU: mul_op = MULH_WU;
            OP_MOD_W:   div_op = MOD_W;
            OP_DIV_WU:  div_op = DIV_WU;
            OP_MOD_WU:  div_op = MOD_WU;
            default: ;
        endcase
    end

    assign mul_req.valid = mul_vld;
    assign mul_req.op    = mul_op;
    assign mul_req.src1  = src1_q;
    assign mul_req.src2  = src2_q;
    assign mul_req.dest  = dest_q;
    assign mul_req.pc    = pc_q;

    assign div_req.valid = div_vld;
    assign div_req.op    = div_op;
    assign div_req.src1  = src1_q;
    assign div_req.src2  = src2_q;
    assign div_req.dest  = dest_q;
    assign div_req.pc    = pc_q;

    a_one_unit: assert property (@(posedge clk) disable iff (reset)
        (mul_req.valid || div_req.valid) |-> busy && !(mul_req.valid && div_req.valid));
endmodule

/* hdl/booth_multiplier.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module booth_multiplier import muldiv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    exu_req_if.unit req,
    exu_resp_if.unit resp
);
    localparam int EXT_W = `MD_XLEN + 2;
    localparam int ACC_W = 2 * EXT_W;
    localparam int QS_W  = EXT_W + 1;
    localparam int CNT_W = $clog2(`MD_MUL_ITERS + 1);

    logic [CNT_W-1:0]     cnt;
    logic                 done;
    logic [EXT_W-1:0]     mcand;
    logic [QS_W-1:0]      qs;
    logic [ACC_W-1:0]     acc;
    mul_op_t              op_q;
    logic [`MD_REG_W-1:0] dest_q;
    logic [`MD_XLEN-1:0]  pc_q;
    logic                 sgn;
    logic [EXT_W-1:0]     ext_m;
    logic [QS_W-1:0]      qs_init;

    // Partial product for one Booth group.
    function automatic logic [ACC_W-1:0] booth_pp(input logic [2:0] grp,
                                                 input logic [EXT_W-1:0] mc);
        logic [ACC_W-1:0] m1;
        m1 = {{EXT_W{mc[EXT_W-1]}}, mc};
        case (grp)
            3'b001, 3'b010: booth_pp = m1;
            3'b011:         booth_pp = m1 << 1;
            3'b100:         booth_pp = -(m1 << 1);
            3'b101, 3'b110: booth_pp = -m1;
            default:        booth_pp = '0;
        endcase
    endfunction

    assign sgn     = (req.op != MULH_WU);
    assign ext_m   = {{2{sgn & req.src1[`MD_XLEN-1]}}, req.src1};
    assign qs_init = {{2{sgn & req.src2[`MD_XLEN-1]}}, req.src2, 1'b0};

    assign req.ready = (cnt == '0) & ~done;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            if (req.valid && req.ready) begin
                cnt <= CNT_W'(`MD_MUL_ITERS);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    done <= 1'b1;
                end
            end
            if (resp.valid && resp.ready) begin
                done <= 1'b0;
            end
        end
    end

    // MSB-first scan, so the accumulator shifts left.
    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            mcand  <= ext_m;
            qs     <= qs_init << 2;
            acc    <= booth_pp(qs_init[QS_W-1 -: 3], ext_m);  // Top group.
            op_q   <= req.op;
            dest_q <= req.dest;
            pc_q   <= req.pc;
        end else if (cnt != '0) begin
            acc <= (acc << 2) + booth_pp(qs[QS_W-1 -: 3], mcand);
            qs  <= qs << 2;
        end
    end

    assign resp.valid  = done;
    assign resp.result = (op_q == MUL_W) ? acc[`MD_XLEN-1:0]
                                         : acc[2*`MD_XLEN-1:`MD_XLEN];
    assign resp.dest   = dest_q;
    assign resp.pc     = pc_q;

    a_hold: assert property (@(posedge clk) disable iff (reset)
        resp.valid && !resp.ready |=>
            resp.valid && $stable(resp.result) && $stable(resp.dest) && $stable(resp.pc));
endmodule

/* hdl/iter_divider.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module iter_divider import muldiv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    exu_req_if.unit req,
    exu_resp_if.unit resp
);
    localparam int CNT_W = $clog2(`MD_DIV_ITERS + 1);

    logic [CNT_W-1:0]     cnt;
    logic                 done;
    logic [`MD_XLEN-1:0]  rem_q;
    logic [`MD_XLEN-1:0]  quo_q;
    logic [`MD_XLEN-1:0]  dvs_q;
    logic                 q_neg;
    logic                 r_neg;
    logic                 dz;
    logic                 want_rem;
    logic [`MD_REG_W-1:0] dest_q;
    logic [`MD_XLEN-1:0]  pc_q;
    logic                 sgn;
    logic                 neg1;
    logic                 neg2;
    logic [`MD_XLEN-1:0]  mag1;
    logic [`MD_XLEN-1:0]  mag2;
    logic [`MD_XLEN:0]    shifted;
    logic [`MD_XLEN+1:0]  diff;
    logic [`MD_XLEN-1:0]  quo_fix;
    logic [`MD_XLEN-1:0]  rem_fix;

    // Operand magnitudes for the signed forms.
    always_comb begin
        sgn  = (req.op == DIV_W) || (req.op == MOD_W);
        neg1 = sgn & req.src1[`MD_XLEN-1];
        neg2 = sgn & req.src2[`MD_XLEN-1];
        mag1 = neg1 ? -req.src1 : req.src1;
        mag2 = neg2 ? -req.src2 : req.src2;
    end

    // Trial subtraction, sign bit decides.
    assign shifted = {rem_q, quo_q[`MD_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_q};

    assign req.ready = (cnt == '0) & ~done;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            if (req.valid && req.ready) begin
                cnt <= CNT_W'(`MD_DIV_ITERS);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin
                    done <= 1'b1;
                end
            end
            if (resp.valid && resp.ready) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            rem_q    <= '0;
            quo_q    <= mag1;  // Dividend bits shift out as quotient bits shift in.
            dvs_q    <= mag2;
            q_neg    <= neg1 ^ neg2;
            r_neg    <= neg1;
            dz       <= (req.src2 == '0);
            want_rem <= (req.op == MOD_W) || (req.op == MOD_WU);
            dest_q   <= req.dest;
            pc_q     <= req.pc;
        end else if (cnt != '0) begin
            if (!diff[`MD_XLEN+1]) begin
                rem_q <= diff[`MD_XLEN-1:0];
                quo_q <= {quo_q[`MD_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`MD_XLEN-1:0];
                quo_q <= {quo_q[`MD_XLEN-2:0], 1'b0};
            end
        end
    end

    // Divide by zero leaves the dividend in rem_q.
    assign quo_fix = dz ? '1 : (q_neg ? -quo_q : quo_q);
    assign rem_fix = r_neg ? -rem_q : rem_q;

    assign resp.valid  = done;
    assign resp.result = want_rem ? rem_fix : quo_fix;
    assign resp.dest   = dest_q;
    assign resp.pc     = pc_q;

    a_no_early: assert property (@(posedge clk) disable iff (reset)
        cnt != '0 |-> !resp.valid);
endmodule

/* hdl/wb_commit.sv */
`timescale 1ns/1ps

module wb_commit import muldiv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    exu_resp_if.commit mul_resp,
    exu_resp_if.commit div_resp,
    output logic       out_valid,
    input  logic       out_ready,
    output commit_t    out_rec,
    output logic       commit_fire
);
    logic    full;
    commit_t rec_q;

    // Units hold their result while this entry is occupied.
    assign mul_resp.ready = ~full;
    assign div_resp.ready = ~full;

    assign out_valid   = full;
    assign out_rec     = rec_q;
    assign commit_fire = full & out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (commit_fire) begin
            full <= 1'b0;
        end else if (!full && (mul_resp.valid || div_resp.valid)) begin
            full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!full) begin
            if (mul_resp.valid) begin
                rec_q.dest   <= mul_resp.dest;
                rec_q.pc     <= mul_resp.pc;
                rec_q.result <= mul_resp.result;
            end else if (div_resp.valid) begin
                rec_q.dest   <= div_resp.dest;
                rec_q.pc     <= div_resp.pc;
                rec_q.result <= div_resp.result;
            end
        end
    end

    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(mul_resp.valid && div_resp.valid));
endmodule

/* hdl/muldiv_top.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_top import muldiv_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  md_op_t               in_op,
    input  logic [`MD_XLEN-1:0]  in_src1,
    input  logic [`MD_XLEN-1:0]  in_src2,
    input  logic [`MD_REG_W-1:0] in_dest,
    input  logic [`MD_XLEN-1:0]  in_pc,
    output logic                 in_ready,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic [`MD_REG_W-1:0] out_dest,
    output logic [`MD_XLEN-1:0]  out_pc,
    output logic [`MD_XLEN-1:0]  out_data
);
    commit_t out_rec;
    logic    commit_fire;

    exu_req_if #(.op_t(mul_op_t)) mul_req ();
    exu_req_if #(.op_t(div_op_t)) div_req ();
    exu_resp_if                   mul_resp ();
    exu_resp_if                   div_resp ();

    ex_issue u_issue (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_src1     (in_src1),
        .in_src2     (in_src2),
        .in_dest     (in_dest),
        .in_pc       (in_pc),
        .in_ready    (in_ready),
        .commit_fire (commit_fire),
        .mul_req     (mul_req),
        .div_req     (div_req)
    );

    booth_multiplier u_mul (
        .clk   (clk),
        .reset (reset),
        .req   (mul_req),
        .resp  (mul_resp)
    );

    iter_divider u_div (
        .clk   (clk),
        .reset (reset),
        .req   (div_req),
        .resp  (div_resp)
    );

    wb_commit u_commit (
        .clk         (clk),
        .reset       (reset),
        .mul_resp    (mul_resp),
        .div_resp    (div_resp),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_rec     (out_rec),
        .commit_fire (commit_fire)
    );

    assign out_dest = out_rec.dest;
    assign out_pc   = out_rec.pc;
    assign out_data = out_rec.result;
endmodule

/* testbench/tb_muldiv.sv */
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module tb_muldiv import muldiv_pkg::*; ();
    localparam int MUL_LAT     = 19;
    localparam int DIV_LAT     = 35;
    localparam int N_OPS       = 299;  // 75 + 120 + 80 + 12 + 12.
    localparam int CYCLE_LIMIT = 40 * N_OPS + 200;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    md_op_t               in_op;
    logic [`MD_XLEN-1:0]  in_src1;
    logic [`MD_XLEN-1:0]  in_src2;
    logic [`MD_REG_W-1:0] in_dest;
    logic [`MD_XLEN-1:0]  in_pc;
    logic                 in_ready;
    logic                 out_valid;
    logic                 out_ready;
    logic [`MD_REG_W-1:0] out_dest;
    logic [`MD_XLEN-1:0]  out_pc;
    logic [`MD_XLEN-1:0]  out_data;
    int                   cycles;
    int                   seq;
    logic [`MD_XLEN-1:0]  corners [5];

    muldiv_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_src1   (in_src1),
        .in_src2   (in_src2),
        .in_dest   (in_dest),
        .in_pc     (in_pc),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dest  (out_dest),
        .out_pc    (out_pc),
        .out_data  (out_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result");
            abort_run();
        end
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic check_data(input string name, input logic [`MD_XLEN-1:0] exp,
                              input logic [`MD_XLEN-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_dest(input string name, input logic [`MD_REG_W-1:0] exp,
                              input logic [`MD_REG_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rec(input string name, input commit_t exp, input commit_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Expected result from the operation rules.
    function automatic logic [`MD_XLEN-1:0] model_result(input md_op_t op,
                                                         input logic [`MD_XLEN-1:0] a,
                                                         input logic [`MD_XLEN-1:0] b);
        logic signed [2*`MD_XLEN-1:0] ps;
        logic [2*`MD_XLEN-1:0]        pu;
        logic signed [`MD_XLEN-1:0]   sa;
        logic signed [`MD_XLEN-1:0]   sb;
        logic signed [`MD_XLEN-1:0]   sq;
        logic                         ovf;
        ps  = $signed({{`MD_XLEN{a[`MD_XLEN-1]}}, a}) * $signed({{`MD_XLEN{b[`MD_XLEN-1]}}, b});
        pu  = {{`MD_XLEN{1'b0}}, a} * {{`MD_XLEN{1'b0}}, b};
        sa  = a;
        sb  = b;
        ovf = (a == {1'b1, {(`MD_XLEN-1){1'b0}}}) && (b == '1);
        if (op == OP_MUL_W) return pu[`MD_XLEN-1:0];
        if (op == OP_MULH_W) return ps[2*`MD_XLEN-1:`MD_XLEN];
        if (op == OP_MULH_WU) return pu[2*`MD_XLEN-1:`MD_XLEN];
        if (b == '0) begin
            return (op == OP_DIV_W || op == OP_DIV_WU) ? '1 : a;  // Divide by zero.
        end
        if (op == OP_DIV_W) begin
            if (ovf) return a;
            sq = sa / sb;
            return sq;
        end
        if (op == OP_MOD_W) begin
            if (ovf) return '0;
            sq = sa % sb;
            return sq;
        end
        if (op == OP_DIV_WU) return a / b;
        return a % b;
    endfunction

    // One operation end to end with the output held back for stall cycles.
    task automatic run_op(input md_op_t op, input logic [`MD_XLEN-1:0] a,
                          input logic [`MD_XLEN-1:0] b, input int stall);
        commit_t exp_rec;
        commit_t held_rec;
        int      lat;
        int      held;
        logic    is_mul;
        is_mul         = (op == OP_MUL_W) || (op == OP_MULH_W) || (op == OP_MULH_WU);
        exp_rec.dest   = `MD_REG_W'(seq);
        exp_rec.pc     = `MD_XLEN'(32'h0000_1000 + 4 * seq);  // Program order tag.
        exp_rec.result = model_result(op, a, b);
        seq++;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_op     <= op;
        in_src1   <= a;
        in_src2   <= b;
        in_dest   <= exp_rec.dest;
        in_pc     <= exp_rec.pc;
        out_ready <= (stall == 0);
        do @(posedge clk); while (!in_ready);
        in_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (!out_valid) check_bit("in_ready", 1'b0, in_ready);
        end while (!out_valid);
        check_latency("latency", is_mul ? MUL_LAT : DIV_LAT, lat);
        check_bit("in_ready", 1'b0, in_ready);
        held_rec = {out_dest, out_pc, out_data};
        check_dest("out_dest", exp_rec.dest, out_dest);
        check_data("out_data", exp_rec.result, out_data);
        check_rec("out_rec", exp_rec, held_rec);
        held = 0;
        while (held < stall) begin
            if (held == stall - 1) out_ready <= 1'b1;
            @(posedge clk);
            held++;
            check_bit("out_valid", 1'b1, out_valid);
            check_bit("in_ready", 1'b0, in_ready);
            check_rec("out_rec", held_rec, {out_dest, out_pc, out_data});
        end
        @(posedge clk);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_ready", 1'b1, in_ready);  // Free again after the transfer.
    endtask

    task automatic reset_values();
        @(posedge clk);
        check_bit("in_ready", 1'b1, in_ready);
        check_bit("out_valid", 1'b0, out_valid);
    endtask

    task automatic mul_corner_cases();
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int k = 0; k < 3; k++) begin
                    run_op(md_op_t'(k), corners[i], corners[j], 0);
                end
            end
        end
    endtask

    task automatic mul_random_pairs();
        logic [`MD_XLEN-1:0] a;
        logic [`MD_XLEN-1:0] b;
        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            b = $urandom;
            for (int k = 0; k < 3; k++) begin
                run_op(md_op_t'(k), a, b, 0);
            end
        end
    endtask

    task automatic div_random_pairs();
        logic [`MD_XLEN-1:0] a;
        logic [`MD_XLEN-1:0] b;
        for (int i = 0; i < 20; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);  // Spread of divisor sizes.
            for (int k = 3; k < 7; k++) begin
                run_op(md_op_t'(k), a, b, 0);
            end
        end
    endtask

    task automatic div_special_cases();
        for (int k = 3; k < 7; k++) begin
            run_op(md_op_t'(k), 32'h0000_0005, '0, 0);
            run_op(md_op_t'(k), 32'h8000_0000, '0, 0);
            run_op(md_op_t'(k), 32'h8000_0000, 32'hffff_ffff, 0);
        end
    endtask

    task automatic stalled_output();
        for (int i = 0; i < 12; i++) begin
            run_op(md_op_t'($urandom % 7), $urandom, $urandom, int'($urandom % 21));
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_op     = OP_MUL_W;
        in_src1   = '0;
        in_src2   = '0;
        in_dest   = '0;
        in_pc     = '0;
        out_ready = 1'b1;
        cycles    = 0;
        seq       = 0;
        corners   = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                      32'h8000_0000, 32'h7fff_ffff};
        void'($urandom(32'ha0d3));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        reset_values();
        mul_corner_cases();
        mul_random_pairs();
        div_random_pairs();
        div_special_cases();
        stalled_output();
        $display("STATUS: PASS");
        $finish;
    end
endmodule

/* compile.f */
+incdir+include
hdl/muldiv_pkg.sv
hdl/exu_req_if.sv
hdl/exu_resp_if.sv
hdl/ex_issue.sv
hdl/booth_multiplier.sv
hdl/iter_divider.sv
hdl/wb_commit.sv
hdl/muldiv_top.sv
testbench/tb_muldiv.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the muldiv testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_muldiv -f compile.f -o sim_muldiv

./obj_dir/sim_muldiv 2>&1 | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
